// File: files.f
+incdir+logic
logic/desc_pkg.sv
logic/stream_pkg.sv
logic/desc_fifo.sv
logic/ctrl_in_parser.sv
logic/core_desc_splitter.sv
logic/send_scheduler.sv
logic/core_desc_router.sv
test/tb_clock_gen.sv
test/core_desc_router_properties.sv
test/tb_core_desc_router.sv

// File: logic/core_desc_router.sv
/* Core descriptor router top */

`timescale 1ns/1ps
`default_nettype none

module core_desc_router (
  input  logic                       sys_clk,
  input  logic                       sys_rst,

  // Scheduler control in
  input  logic                       ctrl_in_valid,
  input  stream_pkg::ctrl_beat_t     ctrl_in_beat,
  output logic                       ctrl_in_ready,

  // Descriptors issued by the core
  input  logic                       core_desc_valid,
  input  desc_pkg::desc_word_t       core_desc,
  output logic                       core_desc_ready,

  // Packet engine side
  output logic                       send_desc_valid,
  output desc_pkg::desc_word_t       send_desc,
  input  logic                       send_desc_ready,
  input  logic                       pkt_sent,

  // Scheduler control out
  output logic                       ctrl_out_valid,
  output stream_pkg::ctrl_out_beat_t ctrl_out_beat,
  input  logic                       ctrl_out_ready,

  output logic                       core_reset
);

  logic                 sched_valid;
  desc_pkg::desc_word_t sched_desc;
  logic                 sched_ready;

  logic                 cdata_valid;
  desc_pkg::desc_word_t cdata_desc;
  logic                 cdata_ready;

  logic                 cmsg_valid;
  desc_pkg::desc_word_t cmsg_desc;
  logic                 cmsg_ready;

  ctrl_in_parser i_ctrl_in_parser (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .ctrl_in_valid (ctrl_in_valid),
    .ctrl_in_beat  (ctrl_in_beat),
    .ctrl_in_ready (ctrl_in_ready),
    .core_reset    (core_reset),
    .sched_valid   (sched_valid),
    .sched_desc    (sched_desc),
    .sched_ready   (sched_ready)
  );

  core_desc_splitter i_core_desc_splitter (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .core_desc_valid (core_desc_valid),
    .core_desc       (core_desc),
    .core_desc_ready (core_desc_ready),
    .cdata_valid     (cdata_valid),
    .cdata_desc      (cdata_desc),
    .cdata_ready     (cdata_ready),
    .cmsg_valid      (cmsg_valid),
    .cmsg_desc       (cmsg_desc),
    .cmsg_ready      (cmsg_ready)
  );

  send_scheduler i_send_scheduler (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .sched_valid     (sched_valid),
    .sched_desc      (sched_desc),
    .sched_ready     (sched_ready),
    .cdata_valid     (cdata_valid),
    .cdata_desc      (cdata_desc),
    .cdata_ready     (cdata_ready),
    .cmsg_valid      (cmsg_valid),
    .cmsg_desc       (cmsg_desc),
    .cmsg_ready      (cmsg_ready),
    .send_desc_valid (send_desc_valid),
    .send_desc       (send_desc),
    .send_desc_ready (send_desc_ready),
    .pkt_sent        (pkt_sent),
    .ctrl_out_valid  (ctrl_out_valid),
    .ctrl_out_beat   (ctrl_out_beat),
    .ctrl_out_ready  (ctrl_out_ready)
  );

endmodule

`default_nettype wire

// File: logic/core_desc_splitter.sv
/* Core descriptor splitter */

`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module core_desc_splitter (
  input  logic                 sys_clk,
  input  logic                 sys_rst,

  input  logic                 core_desc_valid,
  input  desc_pkg::desc_word_t core_desc,
  output logic                 core_desc_ready,

  output logic                 cdata_valid,
  output desc_pkg::desc_word_t cdata_desc,
  input  logic                 cdata_ready,

  output logic                 cmsg_valid,
  output desc_pkg::desc_word_t cmsg_desc,
  input  logic                 cmsg_ready
);

  desc_pkg::desc_type_t desc_type;
  logic                 is_data;
  logic                 is_msg;
  logic                 data_din_ready;
  logic                 msg_din_ready;

  assign desc_type = core_desc[`TYPE_MSB:`TYPE_LSB];
  assign is_data   = (desc_type == '0);
  assign is_msg    = (desc_type != '0) && (desc_type < desc_pkg::desc_type_t'(4));

  // Unknown codes are never taken, the core keeps waiting
  assign core_desc_ready = (is_data && data_din_ready) ||
                           (is_msg  && msg_din_ready);

  ////////////////////////////////////////
  // Data sends from the core
  desc_fifo #(
    .DEPTH (`SEND_DESC_DEPTH)
  ) i_data_fifo (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .din_valid  (core_desc_valid && is_data),
    .din        (core_desc),
    .din_ready  (data_din_ready),
    .dout_valid (cdata_valid),
    .dout       (cdata_desc),
    .dout_ready (cdata_ready)
  );

  ////////////////////////////////////////
  // Messages to the scheduler
  desc_fifo #(
    .DEPTH (`SEND_DESC_DEPTH)
  ) i_msg_fifo (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .din_valid  (core_desc_valid && is_msg),
    .din        (core_desc),
    .din_ready  (msg_din_ready),
    .dout_valid (cmsg_valid),
    .dout       (cmsg_desc),
    .dout_ready (cmsg_ready)
  );

endmodule

`default_nettype wire

// File: logic/ctrl_in_parser.sv
/* Control input parser */

`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module ctrl_in_parser (
  input  logic                   sys_clk,
  input  logic                   sys_rst,

  input  logic                   ctrl_in_valid,
  input  stream_pkg::ctrl_beat_t ctrl_in_beat,
  output logic                   ctrl_in_ready,

  output logic                   core_reset,

  output logic                   sched_valid,
  output desc_pkg::desc_word_t   sched_desc,
  input  logic                   sched_ready
);

  logic reset_cmd;

  // Reset command acts on valid alone and never waits for ready
  assign reset_cmd = ctrl_in_valid &&
                     (&ctrl_in_beat.data[`DESC_WIDTH-1 -: `RESET_MARK_WIDTH]);

  // Core is held in reset until the scheduler releases it
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      core_reset <= 1'b1;
    end else if (reset_cmd) begin
      core_reset <= ctrl_in_beat.data[0];
    end
  end

  // Everything else is a send descriptor for the packet engine
  desc_fifo #(
    .DEPTH (`RECV_DESC_DEPTH)
  ) i_sched_fifo (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .din_valid  (ctrl_in_valid && !reset_cmd),
    .din        (ctrl_in_beat.data),
    .din_ready  (ctrl_in_ready),
    .dout_valid (sched_valid),
    .dout       (sched_desc),
    .dout_ready (sched_ready)
  );

endmodule

`default_nettype wire

// File: logic/desc_fifo.sv
/* Descriptor FIFO */

`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module desc_fifo #(
  parameter int DEPTH = `SEND_DESC_DEPTH
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst,

  input  logic                 din_valid,
  input  desc_pkg::desc_word_t din,
  output logic                 din_ready,

  output logic                 dout_valid,
  output desc_pkg::desc_word_t dout,
  input  logic                 dout_ready
);

  localparam int ADDR_W = $clog2(DEPTH);

  desc_pkg::desc_word_t mem [0:DEPTH-1];

  // Extra top bit tells a full buffer from an empty one
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign push = din_valid && !full;
  assign pop  = dout_ready && !empty;

  assign din_ready  = !full;
  assign dout_valid = !empty;

  // Head word falls through as soon as it is written
  assign dout = mem[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/desc_pkg.sv
/* Descriptor types */

`default_nettype none

`include "router_defs.svh"

package desc_pkg;

  ////////////////////////////////////////
  // Descriptor words
  ////////////////////////////////////////

  // Full descriptor as moved between scheduler, core and packet engine
  typedef logic [`DESC_WIDTH-1:0] desc_word_t;

  // Type code in the top nibble of a core descriptor
  // 0 is a data send, 1 to 3 are scheduler messages
  typedef logic [`TYPE_MSB-`TYPE_LSB:0] desc_type_t;

  ////////////////////////////////////////
  // Identifiers
  ////////////////////////////////////////

  // Core number reported to the scheduler
  typedef logic [`CORE_ID_WIDTH-1:0] core_id_t;

endpackage

`default_nettype wire

// File: logic/router_defs.svh
/* Descriptor router constants */

`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Descriptor word and its type code field
`define DESC_WIDTH        64
`define TYPE_MSB          63
`define TYPE_LSB          60

// Top bits of a control word, all ones for a core reset command
`define RESET_MARK_WIDTH  8

// Queue depths, powers of two
`define RECV_DESC_DEPTH   8
`define SEND_DESC_DEPTH   8

// Identifier carried in the control output user field
`define CORE_ID_WIDTH     4
`define CORE_ID           0

`endif

// File: logic/send_scheduler.sv
/* Send and control output arbiters */

`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module send_scheduler (
  input  logic                       sys_clk,
  input  logic                       sys_rst,

  input  logic                       sched_valid,
  input  desc_pkg::desc_word_t       sched_desc,
  output logic                       sched_ready,

  input  logic                       cdata_valid,
  input  desc_pkg::desc_word_t       cdata_desc,
  output logic                       cdata_ready,

  input  logic                       cmsg_valid,
  input  desc_pkg::desc_word_t       cmsg_desc,
  output logic                       cmsg_ready,

  output logic                       send_desc_valid,
  output desc_pkg::desc_word_t       send_desc,
  input  logic                       send_desc_ready,

  input  logic                       pkt_sent,

  output logic                       ctrl_out_valid,
  output stream_pkg::ctrl_out_beat_t ctrl_out_beat,
  input  logic                       ctrl_out_ready
);

  ////////////////////////////////////////
  // Send descriptor arbiter
  ////////////////////////////////////////

  // Scheduler descriptors win over core data sends
  assign send_desc_valid = sched_valid || cdata_valid;
  assign send_desc       = sched_valid ? sched_desc : cdata_desc;
  assign sched_ready     = send_desc_ready && sched_valid;
  assign cdata_ready     = send_desc_ready && !sched_valid;

  // Descriptor handed to the packet engine, released on pkt_sent
  desc_pkg::desc_word_t last_send_desc;

  always_ff @(posedge sys_clk) begin
    if (send_desc_valid && send_desc_ready) begin
      last_send_desc <= send_desc;
    end
  end

  ////////////////////////////////////////
  // Release queue
  ////////////////////////////////////////

  logic                 rel_valid;
  desc_pkg::desc_word_t rel_desc;
  logic                 rel_ready;

  // A strobe into a full queue is dropped
  desc_fifo #(
    .DEPTH (`SEND_DESC_DEPTH)
  ) i_release_fifo (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .din_valid  (pkt_sent),
    .din        (last_send_desc),
    .din_ready  (),
    .dout_valid (rel_valid),
    .dout       (rel_desc),
    .dout_ready (rel_ready)
  );

  ////////////////////////////////////////
  // Control output arbiter
  ////////////////////////////////////////

  // Releases go ahead of core messages
  assign ctrl_out_valid = rel_valid || cmsg_valid;
  assign rel_ready      = ctrl_out_ready && rel_valid;
  assign cmsg_ready     = ctrl_out_ready && !rel_valid;

  always_comb begin
    ctrl_out_beat.data = rel_valid ? rel_desc : cmsg_desc;
    ctrl_out_beat.last = 1'b1;
    ctrl_out_beat.user = desc_pkg::core_id_t'(`CORE_ID);
  end

endmodule

`default_nettype wire

// File: logic/stream_pkg.sv
/* Control stream beat types */

`default_nettype none

package stream_pkg;

  ////////////////////////////////////////
  // Control stream payloads
  ////////////////////////////////////////

  // Beat arriving from the scheduler
  typedef struct packed {
    desc_pkg::desc_word_t data;
    logic                 last;
  } ctrl_beat_t;

  // Beat going back to the scheduler
  // last is always set, every message is a single beat
  typedef struct packed {
    desc_pkg::desc_word_t data;
    logic                 last;
    desc_pkg::core_id_t   user;
  } ctrl_out_beat_t;

  // The send descriptor channel carries a bare desc_pkg::desc_word_t
  // next to its valid and ready

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the descriptor router testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f files.f \
  --top-module tb_core_desc_router \
  -o sim_core_desc_router

# Keep the log even when the simulator exits with an error
./obj_dir/sim_core_desc_router > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// File: test/core_desc_router_properties.sv
/* Descriptor router assertions */

`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module core_desc_router_properties (
  input logic                       sys_clk,
  input logic                       sys_rst,
  input logic                       send_desc_valid,
  input desc_pkg::desc_word_t       send_desc,
  input logic                       send_desc_ready,
  input logic                       sched_valid,
  input logic                       ctrl_out_valid,
  input stream_pkg::ctrl_out_beat_t ctrl_out_beat,
  input logic                       ctrl_out_ready,
  input logic                       cmsg_valid,
  input logic                       core_desc_valid,
  input desc_pkg::desc_word_t       core_desc,
  input logic                       core_desc_ready,
  input logic                       core_reset
);

  // Outputs idle and core held right after reset
  reset_state: assert property (@(posedge sys_clk)
    sys_rst |=> (!send_desc_valid && !ctrl_out_valid && core_reset))
    else $error("Outputs not in reset state after sys_rst");

  ////////////////////////////////////////
  // Back-pressure
  send_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
    send_desc_valid && !send_desc_ready |=> send_desc_valid)
    else $error("send_desc_valid dropped while not ready");

  // A scheduler descriptor on the port cannot be overtaken
  send_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
    sched_valid && !send_desc_ready |=> $stable(send_desc))
    else $error("send_desc changed while held");

  ctrl_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
    ctrl_out_valid && !ctrl_out_ready |=> ctrl_out_valid)
    else $error("ctrl_out_valid dropped while not ready");

  // A release beat stays on the port until taken
  ctrl_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
    ctrl_out_valid && !ctrl_out_ready && !cmsg_valid |=> $stable(ctrl_out_beat))
    else $error("ctrl_out_beat changed while held");

  ////////////////////////////////////////
  // Descriptor decode and beat format
  refused_type: assert property (@(posedge sys_clk) disable iff (sys_rst)
    core_desc_valid && (core_desc[`TYPE_MSB:`TYPE_LSB] > 4'd3) |-> !core_desc_ready)
    else $error("core_desc_ready high for an unknown type code");

  single_beat: assert property (@(posedge sys_clk) disable iff (sys_rst)
    ctrl_out_valid |-> ctrl_out_beat.last)
    else $error("ctrl_out last bit low");

endmodule

bind core_desc_router core_desc_router_properties i_props (
  .sys_clk         (sys_clk),
  .sys_rst         (sys_rst),
  .send_desc_valid (send_desc_valid),
  .send_desc       (send_desc),
  .send_desc_ready (send_desc_ready),
  .sched_valid     (sched_valid),
  .ctrl_out_valid  (ctrl_out_valid),
  .ctrl_out_beat   (ctrl_out_beat),
  .ctrl_out_ready  (ctrl_out_ready),
  .cmsg_valid      (cmsg_valid),
  .core_desc_valid (core_desc_valid),
  .core_desc       (core_desc),
  .core_desc_ready (core_desc_ready),
  .core_reset      (core_reset)
);

`default_nettype wire

// File: test/tb_clock_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic sys_clk,
  output logic sys_rst
);

  initial begin
    sys_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end
  end

  // Reset drops on the falling edge after RST_CYCLES rising edges
  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: test/tb_core_desc_router.sv
/* Descriptor router testbench */

`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module tb_core_desc_router;

  localparam int NUM_RAND    = 40;
  localparam int BAD_CYCLES  = 10;
  // Reset commands, directed beats, random beats and the refused descriptor
  localparam int TOTAL_BEATS = 5 + 3 + 2 * NUM_RAND + BAD_CYCLES;
  localparam int MAX_CYCLES  = 4 * TOTAL_BEATS + 200;

  logic                       sys_clk;
  logic                       sys_rst;
  logic                       ctrl_in_valid;
  stream_pkg::ctrl_beat_t     ctrl_in_beat;
  logic                       ctrl_in_ready;
  logic                       core_desc_valid;
  desc_pkg::desc_word_t       core_desc;
  logic                       core_desc_ready;
  logic                       send_desc_valid;
  desc_pkg::desc_word_t       send_desc;
  logic                       send_desc_ready;
  logic                       pkt_sent;
  logic                       ctrl_out_valid;
  stream_pkg::ctrl_out_beat_t ctrl_out_beat;
  logic                       ctrl_out_ready;
  logic                       core_reset;

  // Reference model, one queue per source
  desc_pkg::desc_word_t sched_q[$];
  desc_pkg::desc_word_t cdata_q[$];
  desc_pkg::desc_word_t msg_q[$];
  desc_pkg::desc_word_t rel_q[$];
  desc_pkg::desc_word_t last_sent;
  logic                 exp_reset;
  logic                 send_fired;
  logic                 hold_send;
  logic                 hold_ctrl;
  int                   cycle_count;
  int unsigned          seed_value;

  tb_clock_gen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (3)
  ) i_clock_gen (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst)
  );

  core_desc_router i_core_desc_router (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .ctrl_in_valid   (ctrl_in_valid),
    .ctrl_in_beat    (ctrl_in_beat),
    .ctrl_in_ready   (ctrl_in_ready),
    .core_desc_valid (core_desc_valid),
    .core_desc       (core_desc),
    .core_desc_ready (core_desc_ready),
    .send_desc_valid (send_desc_valid),
    .send_desc       (send_desc),
    .send_desc_ready (send_desc_ready),
    .pkt_sent        (pkt_sent),
    .ctrl_out_valid  (ctrl_out_valid),
    .ctrl_out_beat   (ctrl_out_beat),
    .ctrl_out_ready  (ctrl_out_ready),
    .core_reset      (core_reset)
  );

  ////////////////////////////////////////
  // Expected outputs

  // Scheduler sends win whenever one is already queued
  function automatic desc_pkg::desc_word_t predict_send();
    if (sched_q.size() > 0) begin
      return sched_q[0];
    end
    return cdata_q[0];
  endfunction

  // Releases go out before core messages
  function automatic stream_pkg::ctrl_out_beat_t predict_ctrl_out();
    stream_pkg::ctrl_out_beat_t beat;
    beat.data = (rel_q.size() > 0) ? rel_q[0] : msg_q[0];
    beat.last = 1'b1;
    beat.user = desc_pkg::core_id_t'(`CORE_ID);
    return beat;
  endfunction

  // Core ready follows the fullness of the queue that the type code selects
  function automatic logic predict_core_ready();
    desc_pkg::desc_type_t code;
    code = core_desc[`TYPE_MSB:`TYPE_LSB];
    if (code == 4'd0) begin
      return cdata_q.size() < `SEND_DESC_DEPTH;
    end
    if (code <= 4'd3) begin
      return msg_q.size() < `SEND_DESC_DEPTH;
    end
    return 1'b0;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  task automatic check_desc(input string name, input desc_pkg::desc_word_t got,
                            input desc_pkg::desc_word_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Descriptor mismatch");
    end
  endtask

  task automatic check_ctrl_out(input stream_pkg::ctrl_out_beat_t got,
                                input stream_pkg::ctrl_out_beat_t exp);
    if (got !== exp) begin
      $display("Error: ctrl_out_beat is %h, expected %h", got, exp);
      $display("TB FAILED");
      $fatal(1, "Control beat mismatch");
    end
  endtask

  task automatic check_reset(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: core_reset is %h, expected %h", got, exp);
      $display("TB FAILED");
      $fatal(1, "Core reset mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Handshake flag mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Monitor sampling the values from before each rising edge
  always @(posedge sys_clk) begin
    logic rel_full;
    if (sys_rst) begin
      exp_reset  = 1'b1;
      send_fired = 1'b0;
    end else begin
      rel_full = (rel_q.size() == `SEND_DESC_DEPTH);
      check_reset(core_reset, exp_reset);
      check_flag("send_desc_valid", send_desc_valid, (sched_q.size() + cdata_q.size()) > 0);
      check_flag("ctrl_out_valid", ctrl_out_valid, (rel_q.size() + msg_q.size()) > 0);
      check_flag("ctrl_in_ready", ctrl_in_ready, sched_q.size() < `RECV_DESC_DEPTH);
      check_flag("core_desc_ready", core_desc_ready, predict_core_ready());
      send_fired = send_desc_valid && send_desc_ready;
      if (send_fired) begin
        check_desc("send_desc", send_desc, predict_send());
        if (sched_q.size() > 0) begin
          void'(sched_q.pop_front());
        end else begin
          void'(cdata_q.pop_front());
        end
      end
      if (ctrl_out_valid && ctrl_out_ready) begin
        check_ctrl_out(ctrl_out_beat, predict_ctrl_out());
        if (rel_q.size() > 0) begin
          void'(rel_q.pop_front());
        end else begin
          void'(msg_q.pop_front());
        end
      end
      // Release takes the descriptor latched before this edge
      if (pkt_sent && !rel_full) begin
        rel_q.push_back(last_sent);
      end
      if (send_fired) begin
        last_sent = send_desc;
      end
      if (ctrl_in_valid && (&ctrl_in_beat.data[`DESC_WIDTH-1 -: `RESET_MARK_WIDTH])) begin
        exp_reset = ctrl_in_beat.data[0];
      end else if (ctrl_in_valid && ctrl_in_ready) begin
        sched_q.push_back(ctrl_in_beat.data);
      end
      if (core_desc_valid && core_desc_ready) begin
        if (core_desc[`TYPE_MSB:`TYPE_LSB] == 4'd0) begin
          cdata_q.push_back(core_desc);
        end else begin
          msg_q.push_back(core_desc);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  function automatic desc_pkg::desc_word_t make_sched_desc();
    desc_pkg::desc_word_t d;
    d = {$urandom, $urandom};
    // Top bit clear keeps it clear of the reset marker
    d[`DESC_WIDTH-1] = 1'b0;
    return d;
  endfunction

  function automatic desc_pkg::desc_word_t make_core_desc(input desc_pkg::desc_type_t code);
    desc_pkg::desc_word_t d;
    d = {$urandom, $urandom};
    d[`TYPE_MSB:`TYPE_LSB] = code;
    return d;
  endfunction

  // Reset commands last one cycle whatever ready does
  task automatic send_reset_cmd(input logic level);
    desc_pkg::desc_word_t d;
    d = {$urandom, $urandom};
    d[`DESC_WIDTH-1 -: `RESET_MARK_WIDTH] = '1;
    d[0] = level;
    ctrl_in_beat  = '{data: d, last: 1'b1};
    ctrl_in_valid = 1'b1;
    @(negedge sys_clk);
    ctrl_in_valid = 1'b0;
  endtask

  task automatic push_ctrl(input desc_pkg::desc_word_t d);
    ctrl_in_beat  = '{data: d, last: 1'b1};
    ctrl_in_valid = 1'b1;
    @(posedge sys_clk);
    while (!ctrl_in_ready) @(posedge sys_clk);
    @(negedge sys_clk);
    ctrl_in_valid = 1'b0;
  endtask

  task automatic push_core(input desc_pkg::desc_word_t d);
    core_desc       = d;
    core_desc_valid = 1'b1;
    @(posedge sys_clk);
    while (!core_desc_ready) @(posedge sys_clk);
    @(negedge sys_clk);
    core_desc_valid = 1'b0;
  endtask

  task automatic offer_refused_desc();
    core_desc       = make_core_desc(4'd5);
    core_desc_valid = 1'b1;
    repeat (BAD_CYCLES) @(negedge sys_clk);
    core_desc_valid = 1'b0;
  endtask

  // Output readies and the packet-sent strobe after each send
  initial begin
    send_desc_ready = 1'b0;
    ctrl_out_ready  = 1'b0;
    pkt_sent        = 1'b0;
    forever begin
      @(negedge sys_clk);
      send_desc_ready = !hold_send && ($urandom_range(0, 3) != 0);
      ctrl_out_ready  = !hold_ctrl && ($urandom_range(0, 7) != 0);
      pkt_sent        = send_fired;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge sys_clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on timeout");
  end

  initial begin
    seed_value      = $urandom(54);
    hold_send       = 1'b1;
    hold_ctrl       = 1'b1;
    ctrl_in_valid   = 1'b0;
    ctrl_in_beat    = '0;
    core_desc_valid = 1'b0;
    core_desc       = '0;
    @(posedge sys_clk);
    while (sys_rst) @(posedge sys_clk);
    @(negedge sys_clk);

    send_reset_cmd(1'b0);
    send_reset_cmd(1'b1);
    send_reset_cmd(1'b0);
    repeat (2) @(negedge sys_clk);

    // Both send sources and a core message wait behind held readies
    push_ctrl(make_sched_desc());
    push_core(make_core_desc(4'd0));
    push_core(make_core_desc(4'd2));
    repeat (2) @(negedge sys_clk);
    @(posedge sys_clk);
    hold_send = 1'b0;
    repeat (8) @(negedge sys_clk);
    @(posedge sys_clk);
    hold_ctrl = 1'b0;
    @(negedge sys_clk);

    fork
      begin
        for (int i = 0; i < NUM_RAND; i++) begin
          if (i == NUM_RAND / 2) begin
            send_reset_cmd(1'b1);
            send_reset_cmd(1'b0);
          end
          push_ctrl(make_sched_desc());
          repeat ($urandom_range(0, 1)) @(negedge sys_clk);
        end
      end
      begin
        for (int i = 0; i < NUM_RAND; i++) begin
          if (i == NUM_RAND / 2) begin
            offer_refused_desc();
          end
          push_core(make_core_desc(desc_pkg::desc_type_t'($urandom_range(0, 3))));
          repeat ($urandom_range(0, 1)) @(negedge sys_clk);
        end
      end
    join

    // Drain every queue, then watch a few idle cycles
    @(negedge sys_clk);
    while ((sched_q.size() + cdata_q.size() + msg_q.size() + rel_q.size()) > 0 ||
           send_fired) begin
      @(negedge sys_clk);
    end
    repeat (5) @(negedge sys_clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
